/* pBusPkg.sv */
package pBusPkg;

	localparam int PBUS_W = 24;	// Pixel bus width
	localparam int CROM_W = 25;	// Sprite C ROM address
	localparam int SROM_W = 16;	// Fix S ROM address
	localparam int L0ROM_W = 16;	// Line zoom ROM address
	localparam int FIX_TILE_W = 12;	// Fix tile number
	localparam int SPR_TILE_W = 20;	// Sprite tile number
	localparam int FIX_LINE_W = 3;	// Fix tile row
	localparam int SPR_LINE_W = 4;	// Sprite tile row
	localparam int FIX_PAL_W = 4;	// Fix palette number
	localparam int SPR_PAL_W = 8;	// Sprite palette number
	localparam int XPOS_W = 8;	// Sprite X position
	localparam int L0DATA_W = 8;	// L0 ROM data byte

	localparam logic [3:0] LOAD_SLOT = 4'd15;	// Clients load here
	localparam logic [3:0] L0_END_SLOT = 4'd5;	// Last LO slot, L0 byte valid

	typedef enum logic [2:0]
	{
		SLOT_ST,	// Sprite C ROM address
		SLOT_LO,	// L0 ROM address
		SLOT_SP,	// Sprite palette
		SLOT_FT,	// Fix ROM address
		SLOT_X,		// Sprite X position
		SLOT_FP		// Fix palette
	} slotKind;

	// Fixed slot map of one 16-cycle period
	function automatic slotKind slotOf(input logic [3:0] slot);
		slotKind kind;
		kind = SLOT_ST;	// Slot 0
		case (slot)
			4'd1, 4'd2, 4'd3, 4'd4, 4'd5:		kind = SLOT_LO;
			4'd6:					kind = SLOT_SP;
			4'd7, 4'd8:				kind = SLOT_FT;
			4'd9, 4'd10, 4'd11, 4'd12, 4'd13:	kind = SLOT_X;
			4'd14, 4'd15:				kind = SLOT_FP;
			default:				kind = SLOT_ST;
		endcase
		return kind;
	endfunction

endpackage

/* fixFetch.sv */
`timescale 1ns/100ps

module fixFetch
(
	input  logic					CLK_24M,
	input  logic					nRESET,
	input  logic [3:0]				slotNum,	// From arbiter
	input  logic					fixValid,
	output logic					fixReady,
	input  logic [pBusPkg::FIX_TILE_W-1:0]	fixTile,
	input  logic [pBusPkg::FIX_LINE_W-1:0]	fixLine,
	input  logic [pBusPkg::FIX_PAL_W-1:0]	fixPal,
	output logic					fixHeld,	// Owns FT and FP slots
	output logic [pBusPkg::PBUS_W-1:0]		fixAddrWord,
	output logic [pBusPkg::PBUS_W-1:0]		fixPalWord
);

	typedef enum logic [1:0]
	{
		FIX_IDLE,	// No request
		FIX_HALF0,	// First byte pair
		FIX_HALF1	// Second byte pair
	} fixState;

	fixState state;
	logic loadSlot;
	logic halfBit;	// S2H1 style pair select
	logic [pBusPkg::FIX_TILE_W-1:0] tileReg;
	logic [pBusPkg::FIX_LINE_W-1:0] lineReg;
	logic [pBusPkg::FIX_PAL_W-1:0] palReg;

	assign loadSlot = (slotNum == pBusPkg::LOAD_SLOT);
	assign fixReady = loadSlot && (state != FIX_HALF0);	// Busy only before 2nd half
	assign fixHeld = (state != FIX_IDLE);

	always_ff @(posedge CLK_24M)
	begin
		if (!nRESET)
		begin
			state <= FIX_IDLE;
			halfBit <= 1'b0;
		end
		else if (loadSlot)
		begin
			case (state)
				FIX_HALF0:
				begin
					state <= FIX_HALF1;	// Same tile, other pair
					halfBit <= 1'b1;
				end
				default:
				begin
					state <= fixValid ? FIX_HALF0 : FIX_IDLE;	// New tile or go idle
					halfBit <= 1'b0;
				end
			endcase
		end
	end

	// Request payload, taken on handshake
	always_ff @(posedge CLK_24M)
	begin
		if (fixValid && fixReady)
		begin
			tileReg <= fixTile;
			lineReg <= fixLine;
			palReg <= fixPal;
		end
	end

	assign fixAddrWord = {{(pBusPkg::PBUS_W-pBusPkg::SROM_W){1'b0}}, tileReg, lineReg, halfBit};
	assign fixPalWord = {4'h0, palReg, 16'h0000};	// Palette in 19:16

	// Period boundaries only
	fixStateAtLoad: assert property (@(posedge CLK_24M) disable iff (!nRESET)
		!loadSlot |=> $stable(state))
		else $error("fixFetch state moved outside slot 15");

endmodule

/* spriteFetch.sv */
`timescale 1ns/100ps

module spriteFetch
(
	input  logic					CLK_24M,
	input  logic					nRESET,
	input  logic [3:0]				slotNum,	// From arbiter
	input  logic					sprValid,
	output logic					sprReady,
	input  logic [pBusPkg::SPR_TILE_W-1:0]	sprTile,
	input  logic [pBusPkg::SPR_LINE_W-1:0]	sprLine,
	input  logic [pBusPkg::SPR_PAL_W-1:0]	sprPal,
	input  logic [pBusPkg::XPOS_W-1:0]		sprXpos,
	input  logic [pBusPkg::L0ROM_W-1:0]		sprL0Addr,
	input  logic [pBusPkg::L0DATA_W-1:0]	l0RomData,	// Zoom byte back from ROM
	output logic					sprHeld,	// Owns ST, LO, SP and X slots
	output logic [pBusPkg::PBUS_W-1:0]		cromWord,
	output logic [pBusPkg::PBUS_W-1:0]		l0Word,
	output logic [pBusPkg::PBUS_W-1:0]		sprPalWord,
	output logic [pBusPkg::PBUS_W-1:0]		xposWord,
	output logic [pBusPkg::L0DATA_W-1:0]	l0Data,
	output logic					l0Valid
);

	logic loadSlot;
	logic l0Capture;
	logic [pBusPkg::SPR_TILE_W-1:0] tileReg;
	logic [pBusPkg::SPR_LINE_W-1:0] lineReg;
	logic [pBusPkg::SPR_PAL_W-1:0] palReg;
	logic [pBusPkg::XPOS_W-1:0] xposReg;
	logic [pBusPkg::L0ROM_W-1:0] l0AddrReg;
	logic [pBusPkg::CROM_W-1:0] cromAddr;	// Full C ROM address

	assign loadSlot = (slotNum == pBusPkg::LOAD_SLOT);
	assign sprReady = loadSlot;	// One request per period, never stalls
	assign l0Capture = sprHeld && (slotNum == pBusPkg::L0_END_SLOT);

	always_ff @(posedge CLK_24M)
	begin
		if (!nRESET)
		begin
			sprHeld <= 1'b0;
			l0Valid <= 1'b0;
		end
		else
		begin
			if (loadSlot)
				sprHeld <= sprValid;	// Drops when nothing offered
			l0Valid <= l0Capture;	// Single cycle strobe
		end
	end

	// Request payload
	always_ff @(posedge CLK_24M)
	begin
		if (sprValid && sprReady)
		begin
			tileReg <= sprTile;
			lineReg <= sprLine;
			palReg <= sprPal;
			xposReg <= sprXpos;
			l0AddrReg <= sprL0Addr;
		end
	end

	// Zoom byte latched as last LO slot ends
	always_ff @(posedge CLK_24M)
	begin
		if (l0Capture)
			l0Data <= l0RomData;
	end

	assign cromAddr = {tileReg, lineReg, 1'b0};
	assign cromWord = cromAddr[pBusPkg::CROM_W-1:pBusPkg::CROM_W-pBusPkg::PBUS_W];	// Zero LSB implied
	assign l0Word = {{(pBusPkg::PBUS_W-pBusPkg::L0ROM_W){1'b0}}, l0AddrReg};
	assign sprPalWord = {palReg, 16'h0000};	// Palette in 23:16
	assign xposWord = {8'h00, xposReg, 8'h00};	// X in 15:8

	// Strobe right after slot 5, then gone
	l0ValidPulse: assert property (@(posedge CLK_24M) disable iff (!nRESET)
		l0Valid |-> (slotNum == 4'd6) ##1 !l0Valid)
		else $error("l0Valid longer than one cycle or misplaced");

endmodule

/* pBusArbiter.sv */
`timescale 1ns/100ps

module pBusArbiter
(
	input  logic				CLK_24M,
	input  logic				nRESET,
	input  logic				fixHeld,
	input  logic [pBusPkg::PBUS_W-1:0]	fixAddrWord,
	input  logic [pBusPkg::PBUS_W-1:0]	fixPalWord,
	input  logic				sprHeld,
	input  logic [pBusPkg::PBUS_W-1:0]	cromWord,
	input  logic [pBusPkg::PBUS_W-1:0]	l0Word,
	input  logic [pBusPkg::PBUS_W-1:0]	sprPalWord,
	input  logic [pBusPkg::PBUS_W-1:0]	xposWord,
	output logic [3:0]			slotNum,	// Shared slot count
	output logic [pBusPkg::PBUS_W-1:0]	PBUS,
	output logic				nVCS,		// L0 ROM select
	output logic				S1H1
);

	pBusPkg::slotKind kind;

	// Posedge slot counter wrapping every 16 cycles
	always_ff @(posedge CLK_24M)
	begin
		if (!nRESET)
			slotNum <= 4'd0;
		else
			slotNum <= slotNum + 4'd1;
	end

	assign kind = pBusPkg::slotOf(slotNum);

	// Bus owner mux with zero for an idle owner
	always_comb
	begin
		PBUS = '0;
		case (kind)
			pBusPkg::SLOT_ST:
			begin
				if (sprHeld)
					PBUS = cromWord;	// Sprite tile and line
			end
			pBusPkg::SLOT_LO:
			begin
				if (sprHeld)
					PBUS = l0Word;	// Zoom table address
			end
			pBusPkg::SLOT_SP:
			begin
				if (sprHeld)
					PBUS = sprPalWord;
			end
			pBusPkg::SLOT_FT:
			begin
				if (fixHeld)
					PBUS = fixAddrWord;	// Fix tile, line, half
			end
			pBusPkg::SLOT_X:
			begin
				if (sprHeld)
					PBUS = xposWord;
			end
			pBusPkg::SLOT_FP:
			begin
				if (fixHeld)
					PBUS = fixPalWord;
			end
			default:
				PBUS = '0;
		endcase
	end

	assign nVCS = !((kind == pBusPkg::SLOT_LO) && sprHeld);	// Active in LO slots only
	assign S1H1 = slotNum[3];	// Half period clock for fix latch

	// L0 select only inside the LO window of slots 1 to 5
	nVcsInLoSlots: assert property (@(posedge CLK_24M) disable iff (!nRESET)
		!nVCS |-> (slotNum >= 4'd1) && (slotNum <= 4'd5))
		else $error("nVCS low outside LO slots");

endmodule

/* videoPBus.sv */
`timescale 1ns/100ps

module videoPBus
(
	input  logic					CLK_24M,
	input  logic					nRESET,
	input  logic					fixValid,
	output logic					fixReady,
	input  logic [pBusPkg::FIX_TILE_W-1:0]	fixTile,
	input  logic [pBusPkg::FIX_LINE_W-1:0]	fixLine,
	input  logic [pBusPkg::FIX_PAL_W-1:0]	fixPal,
	input  logic					sprValid,
	output logic					sprReady,
	input  logic [pBusPkg::SPR_TILE_W-1:0]	sprTile,
	input  logic [pBusPkg::SPR_LINE_W-1:0]	sprLine,
	input  logic [pBusPkg::SPR_PAL_W-1:0]	sprPal,
	input  logic [pBusPkg::XPOS_W-1:0]		sprXpos,
	input  logic [pBusPkg::L0ROM_W-1:0]		sprL0Addr,
	input  logic [pBusPkg::L0DATA_W-1:0]	l0RomData,
	output logic [pBusPkg::L0DATA_W-1:0]	l0Data,
	output logic					l0Valid,
	output logic [pBusPkg::PBUS_W-1:0]		PBUS,
	output logic					nVCS,
	output logic					S1H1
);

	logic [3:0] slotNum;
	logic fixHeld;
	logic sprHeld;
	logic [pBusPkg::PBUS_W-1:0] fixAddrWord;
	logic [pBusPkg::PBUS_W-1:0] fixPalWord;
	logic [pBusPkg::PBUS_W-1:0] cromWord;
	logic [pBusPkg::PBUS_W-1:0] l0Word;
	logic [pBusPkg::PBUS_W-1:0] sprPalWord;
	logic [pBusPkg::PBUS_W-1:0] xposWord;

	pBusArbiter arb0
	(
		.CLK_24M(CLK_24M), .nRESET(nRESET),
		.fixHeld(fixHeld), .fixAddrWord(fixAddrWord), .fixPalWord(fixPalWord),
		.sprHeld(sprHeld), .cromWord(cromWord), .l0Word(l0Word),
		.sprPalWord(sprPalWord), .xposWord(xposWord),
		.slotNum(slotNum), .PBUS(PBUS), .nVCS(nVCS), .S1H1(S1H1)
	);

	fixFetch fix0
	(
		.CLK_24M(CLK_24M), .nRESET(nRESET), .slotNum(slotNum),
		.fixValid(fixValid), .fixReady(fixReady),
		.fixTile(fixTile), .fixLine(fixLine), .fixPal(fixPal),
		.fixHeld(fixHeld), .fixAddrWord(fixAddrWord), .fixPalWord(fixPalWord)
	);

	spriteFetch spr0
	(
		.CLK_24M(CLK_24M), .nRESET(nRESET), .slotNum(slotNum),
		.sprValid(sprValid), .sprReady(sprReady),
		.sprTile(sprTile), .sprLine(sprLine), .sprPal(sprPal),
		.sprXpos(sprXpos), .sprL0Addr(sprL0Addr), .l0RomData(l0RomData),
		.sprHeld(sprHeld), .cromWord(cromWord), .l0Word(l0Word),
		.sprPalWord(sprPalWord), .xposWord(xposWord),
		.l0Data(l0Data), .l0Valid(l0Valid)
	);

endmodule

/* pBusChecker.sv */
`timescale 1ns/100ps

module pBusChecker
(
	input  logic					CLK_24M,
	input  logic					nRESET,
	input  logic					fixValid,
	input  logic					fixReady,
	input  logic [pBusPkg::FIX_TILE_W-1:0]	fixTile,
	input  logic [pBusPkg::FIX_LINE_W-1:0]	fixLine,
	input  logic [pBusPkg::FIX_PAL_W-1:0]	fixPal,
	input  logic					sprValid,
	input  logic					sprReady,
	input  logic [pBusPkg::SPR_TILE_W-1:0]	sprTile,
	input  logic [pBusPkg::SPR_LINE_W-1:0]	sprLine,
	input  logic [pBusPkg::SPR_PAL_W-1:0]	sprPal,
	input  logic [pBusPkg::XPOS_W-1:0]		sprXpos,
	input  logic [pBusPkg::L0ROM_W-1:0]		sprL0Addr,
	input  logic [pBusPkg::L0DATA_W-1:0]	l0RomData,
	input  logic [pBusPkg::L0DATA_W-1:0]	l0Data,
	input  logic					l0Valid,
	input  logic [pBusPkg::PBUS_W-1:0]		PBUS,
	input  logic					nVCS,
	input  logic					S1H1,
	output logic [3:0]				slot,	// Own slot count for the current cycle
	output int					errors,
	output int					checks
);

	localparam int F_IDLE = 0;
	localparam int F_HALF0 = 1;	// First byte pair
	localparam int F_HALF1 = 2;	// Second byte pair

	int fixSt;
	int period;
	int errCount = 0;
	int checkCount = 0;
	string tag;
	logic [3:0] slotCnt;
	logic sHeld;
	logic expL0Valid;
	logic [7:0] expL0Data;
	logic [11:0] fTile;
	logic [2:0] fLine;
	logic [3:0] fPal;
	logic [19:0] sTile;
	logic [3:0] sLine;
	logic [7:0] sPal;
	logic [7:0] sX;
	logic [15:0] sL0;

	assign slot = slotCnt;
	assign errors = errCount;
	assign checks = checkCount;

	task automatic expectWord(input string name, input logic [23:0] exp, input logic [23:0] act);
		checkCount++;
		if (act !== exp)
		begin
			errCount++;
			$display("Mismatch %s: expected 0x%06h actual 0x%06h", name, exp, act);
		end
	endtask

	task automatic expectBit(input string name, input logic exp, input logic act);
		checkCount++;
		if (act !== exp)
		begin
			errCount++;
			$display("Mismatch %s: expected %0b actual %0b", name, exp, act);
		end
	endtask

	// Word the slot map puts on the bus or zero for an idle owner
	function automatic logic [23:0] busWord(input logic [3:0] s);
		logic [23:0] w;
		logic [24:0] crom;
		crom = {sTile, sLine, 1'b0};	// 25 bit C ROM address
		case (s)
			4'd0:	w = sHeld ? crom[24:1] : 24'h0;	// Bus carries bits 24:1
			4'd1, 4'd2, 4'd3, 4'd4, 4'd5:	w = sHeld ? {8'h00, sL0} : 24'h0;
			4'd6:	w = sHeld ? {sPal, 16'h0000} : 24'h0;
			4'd7, 4'd8:	w = (fixSt != F_IDLE) ? {8'h00, fTile, fLine, fixSt == F_HALF1} : 24'h0;
			4'd14, 4'd15:	w = (fixSt != F_IDLE) ? {4'h0, fPal, 16'h0000} : 24'h0;
			default:	w = sHeld ? {8'h00, sX, 8'h00} : 24'h0;	// Slots 9 to 13
		endcase
		return w;
	endfunction

	// Sampled mid cycle where everything has settled
	always @(negedge CLK_24M)
	begin
		if (nRESET !== 1'b1)
		begin
			slotCnt = 4'd0;
			period = 0;
			fixSt = F_IDLE;
			sHeld = 1'b0;
			expL0Valid = 1'b0;
		end
		else
		begin
			tag = $sformatf(" slot %0d period %0d", slotCnt, period);
			expectWord({"PBUS", tag}, busWord(slotCnt), PBUS);
			expectBit({"nVCS", tag}, !(sHeld && (slotCnt >= 4'd1) && (slotCnt <= 4'd5)), nVCS);
			expectBit({"S1H1", tag}, slotCnt[3], S1H1);
			expectBit({"fixReady", tag}, (slotCnt == 4'd15) && (fixSt != F_HALF0), fixReady);
			expectBit({"sprReady", tag}, slotCnt == 4'd15, sprReady);
			expectBit({"l0Valid", tag}, expL0Valid, l0Valid);
			if (expL0Valid)
				expectWord({"l0Data", tag}, {16'h0000, expL0Data}, {16'h0000, l0Data});
			expL0Valid = sHeld && (slotCnt == 4'd5);	// Byte taken as slot 5 ends
			if (expL0Valid)
				expL0Data = l0RomData;
			if (slotCnt == 4'd15)
			begin
				period++;
				if (fixSt == F_HALF0)
					fixSt = F_HALF1;	// Second pair of the same tile
				else if (fixValid)
				begin
					fixSt = F_HALF0;	// Accepted for the next period
					fTile = fixTile;
					fLine = fixLine;
					fPal = fixPal;
				end
				else
					fixSt = F_IDLE;
				sHeld = sprValid;
				if (sprValid)
				begin
					sTile = sprTile;
					sLine = sprLine;
					sPal = sprPal;
					sX = sprXpos;
					sL0 = sprL0Addr;
				end
			end
			slotCnt = slotCnt + 4'd1;
		end
	end

endmodule

/* tb_videoPBus.sv */
`timescale 1ns/100ps

module tb_videoPBus;

	localparam logic [1:0] ENT_IDLE = 2'd0;	// One period, nothing offered
	localparam logic [1:0] ENT_FIX = 2'd1;
	localparam logic [1:0] ENT_SPR = 2'd2;	// Or'd with ENT_FIX for both
	localparam int NUM_ENT = 11;
	localparam int HS_LIMIT = 64;	// Two periods plus margin
	localparam int IDLE_LIMIT = 20;

	typedef struct packed
	{
		logic [1:0] kind;
		logic [11:0] fTile;
		logic [2:0] fLine;
		logic [3:0] fPal;
		logic [1:0] fStall;	// Periods the fix request must wait
		logic [19:0] sTile;
		logic [3:0] sLine;
		logic [7:0] sPal;
		logic [7:0] sX;
		logic [15:0] sL0;
		logic [7:0] l0Byte;	// ROM answer in slot 5
	} tabEntry;

	logic CLK_24M, nRESET, fixValid, fixReady, sprValid, sprReady, l0Valid, nVCS, S1H1;
	logic [11:0] fixTile;
	logic [2:0] fixLine;
	logic [3:0] fixPal, sprLine, chkSlot;
	logic [19:0] sprTile;
	logic [7:0] sprPal, sprXpos, l0RomData, l0Data, romByte;
	logic [15:0] sprL0Addr;
	logic [23:0] PBUS;
	logic aborted;
	int chkErrors, chkChecks, tbErrors, i;
	tabEntry tab [NUM_ENT];
	string tabName [NUM_ENT];

	videoPBus dut0 (.*);
	pBusChecker chk0 (.*, .slot(chkSlot), .errors(chkErrors), .checks(chkChecks));

	always #2 CLK_24M = ~CLK_24M;	// 4 ns period

	function automatic tabEntry fixEntry(input logic [11:0] tile, input logic [2:0] line,
		input logic [3:0] pal, input logic [1:0] stall);
		tabEntry e;
		e = '0;
		e.kind = ENT_FIX;
		e.fTile = tile;
		e.fLine = line;
		e.fPal = pal;
		e.fStall = stall;
		return e;
	endfunction

	function automatic tabEntry sprEntry(input logic [19:0] tile, input logic [3:0] line,
		input logic [7:0] pal, input logic [7:0] x, input logic [15:0] l0, input logic [7:0] rom);
		tabEntry e;
		e = '0;
		e.kind = ENT_SPR;
		e.sTile = tile;
		e.sLine = line;
		e.sPal = pal;
		e.sX = x;
		e.sL0 = l0;
		e.l0Byte = rom;
		return e;
	endfunction

	task automatic loadTable();
		tab[0] = '0;
		tabName[0] = "idle after reset";
		tab[1] = sprEntry(20'hA5C3E, 4'h7, 8'h3C, 8'h91, 16'hBEEF, 8'h5A);
		tabName[1] = "sprite alone";
		tab[2] = sprEntry(20'h12345, 4'hE, 8'hC3, 8'h0F, 16'h0123, 8'hA7);
		tabName[2] = "sprite back to back";
		tab[3] = '0;
		tabName[3] = "idle between";
		tab[4] = fixEntry(12'hABC, 3'd5, 4'h9, 2'd0);
		tabName[4] = "fix alone";
		tab[5] = fixEntry(12'h5E1, 3'd2, 4'h6, 2'd1);	// Offered in first half of tab[4]
		tabName[5] = "fix back pressure";
		tab[6] = fixEntry(12'h3D7, 3'd7, 4'hF, 2'd1)
			| sprEntry(20'h0F0F0, 4'h3, 8'h5A, 8'h40, 16'h8001, 8'hC6);
		tabName[6] = "fix waits, sprite overlaps";
		tab[7] = '0;
		tabName[7] = "idle under fix";
		tab[8] = fixEntry(12'hFFF, 3'd0, 4'h1, 2'd0)
			| sprEntry(20'hFFFFF, 4'hF, 8'hFF, 8'hFF, 16'hFFFF, 8'h00);
		tabName[8] = "fix and sprite same period";
		tab[9] = sprEntry(20'h00001, 4'h1, 8'h01, 8'h80, 16'h4000, 8'h3E);
		tabName[9] = "sprite beside fix";
		tab[10] = '0;
		tabName[10] = "final idle";
	endtask

	task automatic stepClock();
		@(posedge CLK_24M);
		#0.5;
		l0RomData = (chkSlot == 4'd5) ? romByte : ~romByte;	// Only slot 5 holds the real byte
	endtask

	task automatic applyEntry(input int idx);
		tabEntry e;
		logic fixPend, sprPend, fixFire, sprFire;
		int cycles, stalls;
		e = tab[idx];
		fixPend = e.kind[0];
		sprPend = e.kind[1];
		cycles = 0;
		stalls = 0;
		fixValid = fixPend;
		fixTile = e.fTile;
		fixLine = e.fLine;
		fixPal = e.fPal;
		sprValid = sprPend;
		sprTile = e.sTile;
		sprLine = e.sLine;
		sprPal = e.sPal;
		sprXpos = e.sX;
		sprL0Addr = e.sL0;
		if (e.kind == ENT_IDLE)
		begin
			while (chkSlot != 4'd15 && cycles < IDLE_LIMIT)
			begin
				stepClock();
				cycles++;
			end
			if (chkSlot != 4'd15)
			begin
				$display("Timeout: %s, slot 15 never came", tabName[idx]);
				tbErrors++;
				aborted = 1'b1;
			end
			else
				stepClock();	// Next period loads nothing
		end
		// Handshake seen at the drive point, fires on the coming edge
		while ((fixPend || sprPend) && cycles < HS_LIMIT)
		begin
			fixFire = fixPend && fixReady;
			sprFire = sprPend && sprReady;
			if (fixPend && !fixFire && chkSlot == 4'd15)
				stalls++;	// Slot 15 passed without acceptance
			stepClock();
			if (fixFire)
			begin
				fixValid = 1'b0;
				fixPend = 1'b0;
			end
			if (sprFire)
			begin
				sprValid = 1'b0;
				sprPend = 1'b0;
				romByte = e.l0Byte;	// ROM answer for the held period
			end
			cycles++;
		end
		if (fixPend || sprPend)
		begin
			$display("Timeout: %s, request not accepted within %0d cycles", tabName[idx], HS_LIMIT);
			tbErrors++;
			aborted = 1'b1;
		end
		else if (e.kind[0] && stalls != int'(e.fStall))
		begin
			$display("Mismatch %s fix stall periods: expected %0d actual %0d",
				tabName[idx], e.fStall, stalls);
			tbErrors++;
		end
	endtask

	initial
	begin
		CLK_24M = 1'b0;
		nRESET = 1'b0;
		fixValid = 1'b0;
		fixTile = 12'h000;
		fixLine = 3'd0;
		fixPal = 4'h0;
		sprValid = 1'b0;
		sprTile = 20'h00000;
		sprLine = 4'h0;
		sprPal = 8'h00;
		sprXpos = 8'h00;
		sprL0Addr = 16'h0000;
		l0RomData = 8'h00;
		romByte = 8'h00;
		tbErrors = 0;
		aborted = 1'b0;
		loadTable();
		repeat (16) @(posedge CLK_24M);
		#0.5;
		nRESET = 1'b1;
		for (i = 0; i < NUM_ENT && !aborted; i++)
			applyEntry(i);
		for (i = 0; i < 48 && !aborted; i++)
			stepClock();	// Three periods so held requests finish
		$display("Checks %0d, checker errors %0d, testbench errors %0d",
			chkChecks, chkErrors, tbErrors);
		if (chkErrors == 0 && tbErrors == 0 && chkChecks > 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule

/* compile.f */
pBusPkg.sv
fixFetch.sv
spriteFetch.sv
pBusArbiter.sv
videoPBus.sv
pBusChecker.sv
tb_videoPBus.sv

/* run.sh */
#!/bin/sh
# Build the testbench with Verilator, run it, then search the log for a failure
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log
verilator --binary --timing --assert --timescale 1ns/100ps --top-module tb_videoPBus \
	-f compile.f -o simv > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/simv > sim.log 2>&1
cat sim.log
grep -q "TEST FAIL" sim.log && exit 1
grep -q "TEST PASS" sim.log && exit 0 || exit 1
